// File: hw/bomb_pkg.sv
/*
 * Game constants and shared types. Timer digit widths cap the start time at 7:59.
 * The SPI frame packs minutes, tens and ones into zero-extended nibbles.
 */
`default_nettype none

package bomb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Enumerations.
    typedef enum logic [1:0] {
        GAME_IDLE,
        GAME_PLAYING,
        GAME_DEFUSED,
        GAME_EXPLODED
    } game_state_e;

    typedef enum logic [2:0] {
        WIRE_NONE,
        WIRE_RED,
        WIRE_BLUE,
        WIRE_WHITE,
        WIRE_YELLOW,
        WIRE_BLACK
    } wire_color_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Puzzle and game sizes.
    localparam int NUM_WIRES = 6;
    localparam int WIRE_POS_W = 3;
    localparam int LIVES_W = 2;
    localparam logic [LIVES_W-1:0] START_LIVES = 2'd3;

    // Button vector bit positions.
    localparam int BTN_SELECT = 0;
    localparam int BTN_UP = 1;
    localparam int BTN_RIGHT = 2;
    localparam int BTN_DOWN = 3;
    localparam int BTN_LEFT = 4;
    localparam int BTN_BACK = 5;

    // Timer digits and display link.
    localparam int MIN_W = 3;
    localparam int SEC_TEN_W = 3;
    localparam int SEC_ONE_W = 4;
    localparam int SSDEC_FRAME_W = 12;

endpackage

`default_nettype wire

// File: hw/button_edge_detector.sv
/*
 * Buttons are asynchronous and active high. Each press gives one pulse,
 * three clocks after the input is first sampled high.
 */
`timescale 1ns/1ns
`default_nettype none

module button_edge_detector (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [5:0] button,
    output logic [5:0] button_edge,
    output logic       strobe
);

    logic [5:0] sync_meta;
    logic [5:0] sync_q;
    logic [5:0] prev_q;
    logic [5:0] rise;

    assign rise = sync_q & ~prev_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta   <= '0;
            sync_q      <= '0;
            prev_q      <= '0;
            button_edge <= '0;
            strobe      <= 1'b0;
        end else begin
            sync_meta   <= button;      // First synchroniser stage.
            sync_q      <= sync_meta;
            prev_q      <= sync_q;
            button_edge <= rise;
            strobe      <= |rise;       // Any button pressed.
        end
    end

endmodule

`default_nettype wire

// File: hw/countdown_timer.sv
/*
 * CLKS_PER_SEC must be at least 2, START_SEC within 0..59 and START_MIN within 0..7.
 * Counting runs only while playing is high; time_up holds until the next start.
 */
`timescale 1ns/1ns
`default_nettype none

module countdown_timer #(
    parameter int CLKS_PER_SEC = 50_000_000,
    parameter int START_MIN = 5,
    parameter int START_SEC = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic                          playing,
    output logic [bomb_pkg::MIN_W-1:0]     cnt_min,
    output logic [bomb_pkg::SEC_TEN_W-1:0] cnt_sec_ten,
    output logic [bomb_pkg::SEC_ONE_W-1:0] cnt_sec_one,
    output logic                          time_up
);

    localparam int DIV_W = $clog2(CLKS_PER_SEC + 1);
    localparam int TEN_I = START_SEC / 10;
    localparam int ONE_I = START_SEC % 10;
    localparam logic [bomb_pkg::MIN_W-1:0] LOAD_MIN = START_MIN[bomb_pkg::MIN_W-1:0];
    localparam logic [bomb_pkg::SEC_TEN_W-1:0] LOAD_TEN = TEN_I[bomb_pkg::SEC_TEN_W-1:0];
    localparam logic [bomb_pkg::SEC_ONE_W-1:0] LOAD_ONE = ONE_I[bomb_pkg::SEC_ONE_W-1:0];

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One second divider.
    assign tick = playing && (div_cnt == DIV_W'(CLKS_PER_SEC - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (start || tick) begin
            div_cnt <= '0;
        end else if (playing) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // BCD down-counter.
    assign time_up = (cnt_min == '0) && (cnt_sec_ten == '0) && (cnt_sec_one == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_min     <= LOAD_MIN;
            cnt_sec_ten <= LOAD_TEN;
            cnt_sec_one <= LOAD_ONE;
        end else if (start) begin
            cnt_min     <= LOAD_MIN;
            cnt_sec_ten <= LOAD_TEN;
            cnt_sec_one <= LOAD_ONE;
        end else if (tick && !time_up) begin
            if (cnt_sec_one != '0) begin
                cnt_sec_one <= cnt_sec_one - 1'b1;
            end else begin
                cnt_sec_one <= 4'd9;
                if (cnt_sec_ten != '0) begin
                    cnt_sec_ten <= cnt_sec_ten - 1'b1;
                end else begin
                    cnt_sec_ten <= 3'd5;        // Borrow from minutes.
                    cnt_min     <= cnt_min - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/wire_puzzle.sv
/*
 * Colours are sampled only on start. Target is the highest red wire, else wire 0.
 * Cut wires stay cut until the next start.
 */
`timescale 1ns/1ns
`default_nettype none

module wire_puzzle (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               start,
    input  logic                                               playing,
    input  logic [5:0]                                         button_edge,
    input  logic                                               strobe,
    input  logic [$bits(bomb_pkg::wire_color_e)*bomb_pkg::NUM_WIRES-1:0] wire_colors,
    output logic [bomb_pkg::WIRE_POS_W-1:0]                    wire_pos,
    output logic [bomb_pkg::NUM_WIRES-1:0]                     wire_status,
    output logic                                               wire_clear,
    output logic                                               wire_error
);

    localparam int COLOR_W = $bits(bomb_pkg::wire_color_e);
    localparam int LAST_I = bomb_pkg::NUM_WIRES - 1;
    localparam logic [bomb_pkg::WIRE_POS_W-1:0] LAST_POS = LAST_I[bomb_pkg::WIRE_POS_W-1:0];

    bomb_pkg::wire_color_e                colors_q [bomb_pkg::NUM_WIRES];
    logic [bomb_pkg::WIRE_POS_W-1:0]      target;
    logic                                 active;

    assign active = playing && strobe;

    // Colour latch.
    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < bomb_pkg::NUM_WIRES; i++) begin
                colors_q[i] <= bomb_pkg::wire_color_e'(wire_colors[COLOR_W*i +: COLOR_W]);
            end
        end
    end

    // Later red wires override earlier ones.
    always_comb begin
        target = '0;
        for (int i = 0; i < bomb_pkg::NUM_WIRES; i++) begin
            if (colors_q[i] == bomb_pkg::WIRE_RED) begin
                target = i[bomb_pkg::WIRE_POS_W-1:0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cursor and cutting.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wire_pos    <= '0;
            wire_status <= '0;
            wire_clear  <= 1'b0;
            wire_error  <= 1'b0;
        end else begin
            wire_clear <= 1'b0;
            wire_error <= 1'b0;
            if (start) begin
                wire_pos    <= '0;
                wire_status <= '0;
            end else if (active) begin
                if (button_edge[bomb_pkg::BTN_RIGHT]) begin
                    wire_pos <= (wire_pos == LAST_POS) ? '0 : wire_pos + 1'b1;
                end else if (button_edge[bomb_pkg::BTN_LEFT]) begin
                    wire_pos <= (wire_pos == '0) ? LAST_POS : wire_pos - 1'b1;
                end else if (button_edge[bomb_pkg::BTN_SELECT] && !wire_status[wire_pos]) begin
                    if (wire_pos == target) begin
                        wire_clear <= 1'b1;
                    end else begin
                        wire_status[wire_pos] <= 1'b1;
                        wire_error            <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/game_control.sv
/*
 * Select starts a game from idle, back leaves the end states.
 * A clear beats a time-up or an error arriving in the same cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module game_control (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [5:0]                    button_edge,
    input  logic                          strobe,
    input  logic                          wire_clear,
    input  logic                          wire_error,
    input  logic                          time_up,
    output logic                          start,
    output logic                          playing,
    output bomb_pkg::game_state_e         game_state,
    output logic [bomb_pkg::LIVES_W-1:0]  lives
);

    logic select_hit;
    logic back_hit;

    assign select_hit = strobe && button_edge[bomb_pkg::BTN_SELECT];
    assign back_hit   = strobe && button_edge[bomb_pkg::BTN_BACK];
    assign playing    = (game_state == bomb_pkg::GAME_PLAYING);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Game FSM and lives.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_state <= bomb_pkg::GAME_IDLE;
            lives      <= bomb_pkg::START_LIVES;
            start      <= 1'b0;
        end else begin
            start <= 1'b0;
            case (game_state)
                bomb_pkg::GAME_IDLE: begin
                    if (select_hit) begin
                        game_state <= bomb_pkg::GAME_PLAYING;
                        lives      <= bomb_pkg::START_LIVES;
                        start      <= 1'b1;
                    end
                end

                bomb_pkg::GAME_PLAYING: begin
                    if (wire_clear) begin
                        game_state <= bomb_pkg::GAME_DEFUSED;
                    end else if (time_up && !start) begin
                        // The timer reloads one cycle after start.
                        game_state <= bomb_pkg::GAME_EXPLODED;
                    end else if (wire_error) begin
                        lives <= lives - 1'b1;
                        if (lives == 2'd1) begin
                            game_state <= bomb_pkg::GAME_EXPLODED;  // Last life gone.
                        end
                    end
                end

                bomb_pkg::GAME_DEFUSED,
                bomb_pkg::GAME_EXPLODED: begin
                    if (back_hit) begin
                        game_state <= bomb_pkg::GAME_IDLE;
                    end
                end

                default: begin
                    game_state <= bomb_pkg::GAME_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/ssdec_spi_master.sv
/*
 * Free running. Each frame sends 12 bits MSB first, then holds ss high for
 * two sck periods. Data changes on falling sck; the decoder samples on rising sck.
 */
`timescale 1ns/1ns
`default_nettype none

module ssdec_spi_master #(
    parameter int SCK_HALF = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [bomb_pkg::MIN_W-1:0]     cnt_min,
    input  logic [bomb_pkg::SEC_TEN_W-1:0] cnt_sec_ten,
    input  logic [bomb_pkg::SEC_ONE_W-1:0] cnt_sec_one,
    output logic                          ss,
    output logic                          sck,
    output logic                          sdi
);

    localparam int FRAME_W = bomb_pkg::SSDEC_FRAME_W;
    localparam int PH_W = $clog2(SCK_HALF + 1);
    localparam logic [3:0] LAST_BIT = 4'(FRAME_W - 1);
    localparam logic [3:0] GAP_END = 4'd3;     // Four half periods.

    typedef enum logic {SPI_GAP, SPI_SHIFT} spi_state_e;

    spi_state_e           state;
    logic [PH_W-1:0]      phase;
    logic [3:0]           bit_cnt;    // Also counts gap half periods.
    logic [FRAME_W-1:0]   shift_q;
    logic                 half_tick;
    logic                 frame_start;
    logic                 bit_done;

    assign half_tick   = (phase == PH_W'(SCK_HALF - 1));
    assign frame_start = half_tick && (state == SPI_GAP) && (bit_cnt == GAP_END);
    assign bit_done    = half_tick && (state == SPI_SHIFT) && sck;

    // Digits are captured once per frame.
    always_ff @(posedge clk) begin
        if (frame_start) begin
            shift_q <= {1'b0, cnt_min, 1'b0, cnt_sec_ten, cnt_sec_one};
        end else if (bit_done) begin
            shift_q <= shift_q << 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase counter and frame FSM.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= '0;
            state   <= SPI_GAP;
            bit_cnt <= '0;
            ss      <= 1'b1;
            sck     <= 1'b0;
            sdi     <= 1'b0;
        end else begin
            phase <= half_tick ? '0 : phase + 1'b1;
            if (frame_start) begin
                state   <= SPI_SHIFT;
                bit_cnt <= '0;
                ss      <= 1'b0;
                sdi     <= 1'b0;    // Frame MSB is the pad bit.
            end else if (half_tick && state == SPI_GAP) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (half_tick && !sck) begin
                sck <= 1'b1;
            end else if (bit_done) begin
                sck <= 1'b0;
                if (bit_cnt == LAST_BIT) begin
                    state   <= SPI_GAP;
                    bit_cnt <= '0;
                    ss      <= 1'b1;
                    sdi     <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    sdi     <= shift_q[FRAME_W-2];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/bomb_game.sv
/*
 * Game top. Buttons and wire colours are asynchronous inputs; colours are
 * read when a game starts. Timer digits are exported beside the SPI link.
 */
`timescale 1ns/1ns
`default_nettype none

module bomb_game #(
    parameter int CLKS_PER_SEC = 50_000_000,
    parameter int START_MIN = 5,
    parameter int START_SEC = 0,
    parameter int SCK_HALF = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [5:0]                          button,
    input  logic [3*bomb_pkg::NUM_WIRES-1:0]    wire_colors,    // Wire 0 in the low bits.
    output logic                                ssdec_ss,
    output logic                                ssdec_sck,
    output logic                                ssdec_sdi,
    output bomb_pkg::game_state_e               game_state,
    output logic [bomb_pkg::LIVES_W-1:0]        lives,
    output logic [bomb_pkg::WIRE_POS_W-1:0]     wire_pos,
    output logic [bomb_pkg::NUM_WIRES-1:0]      wire_status,
    output logic [bomb_pkg::MIN_W-1:0]          cnt_min,
    output logic [bomb_pkg::SEC_TEN_W-1:0]      cnt_sec_ten,
    output logic [bomb_pkg::SEC_ONE_W-1:0]      cnt_sec_one
);

    logic [5:0] button_edge;
    logic       strobe;
    logic       start;
    logic       playing;
    logic       time_up;
    logic       wire_clear;
    logic       wire_error;

    button_edge_detector button_edge_detector_0 (
        .clk(clk), .rst_n(rst_n), .button(button),
        .button_edge(button_edge), .strobe(strobe)
    );

    game_control game_control_0 (
        .clk(clk), .rst_n(rst_n), .button_edge(button_edge), .strobe(strobe),
        .wire_clear(wire_clear), .wire_error(wire_error), .time_up(time_up),
        .start(start), .playing(playing), .game_state(game_state), .lives(lives)
    );

    countdown_timer #(
        .CLKS_PER_SEC(CLKS_PER_SEC), .START_MIN(START_MIN), .START_SEC(START_SEC)
    ) countdown_timer_0 (
        .clk(clk), .rst_n(rst_n), .start(start), .playing(playing),
        .cnt_min(cnt_min), .cnt_sec_ten(cnt_sec_ten), .cnt_sec_one(cnt_sec_one),
        .time_up(time_up)
    );

    wire_puzzle wire_puzzle_0 (
        .clk(clk), .rst_n(rst_n), .start(start), .playing(playing),
        .button_edge(button_edge), .strobe(strobe), .wire_colors(wire_colors),
        .wire_pos(wire_pos), .wire_status(wire_status),
        .wire_clear(wire_clear), .wire_error(wire_error)
    );

    ssdec_spi_master #(.SCK_HALF(SCK_HALF)) ssdec_spi_master_0 (
        .clk(clk), .rst_n(rst_n),
        .cnt_min(cnt_min), .cnt_sec_ten(cnt_sec_ten), .cnt_sec_one(cnt_sec_one),
        .ss(ssdec_ss), .sck(ssdec_sck), .sdi(ssdec_sdi)
    );

endmodule

`default_nettype wire

// File: sim/bomb_game_properties.sv
/*
 * Protocol checks on game control and the display link, bound into bomb_game.
 */
`timescale 1ns/1ns
`default_nettype none

module bomb_game_properties (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         start,
    input logic                         wire_clear,
    input logic                         wire_error,
    input logic                         time_up,
    input bomb_pkg::game_state_e        game_state,
    input logic [bomb_pkg::LIVES_W-1:0] lives,
    input logic                         ssdec_ss,
    input logic                         ssdec_sck
);

    start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> !start)
        else $error("start pulse lasted more than one cycle");

    // Lives rise only by the reload at start, and otherwise fall one at a time.
    lives_step: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(lives) |-> (start && lives == bomb_pkg::START_LIVES)
            || ($past(lives) != '0 && lives == $past(lives) - 1'b1))
        else $error("lives changed other than by a start reload or a single loss");

    sck_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        ssdec_ss |-> !ssdec_sck)
        else $error("sck toggled while ss was high");

    // Only a clear, an error or time-up ends a game.
    playing_exit: assert property (@(posedge clk) disable iff (!rst_n)
        (game_state == bomb_pkg::GAME_PLAYING) && !wire_clear && !wire_error && !time_up
            |=> (game_state == bomb_pkg::GAME_PLAYING))
        else $error("game left playing without a cause");

endmodule

bind bomb_game bomb_game_properties bomb_game_properties_0 (
    .clk(clk), .rst_n(rst_n), .start(start), .wire_clear(wire_clear),
    .wire_error(wire_error), .time_up(time_up), .game_state(game_state),
    .lives(lives), .ssdec_ss(ssdec_ss), .ssdec_sck(ssdec_sck)
);

`default_nettype wire

// File: sim/bomb_game_tb.sv
/*
 * Start time is 0:05 at 20 clocks per second, so each game ends within about
 * 100 clocks of its start. Buttons are held 4 clocks and released 4 clocks.
 */
`timescale 1ns/1ns
`default_nettype none

module bomb_game_tb;

    typedef enum logic [1:0] {ACT_SOLVE, ACT_WRONG, ACT_TIMEOUT} action_e;

    localparam int NUM_TESTS = 6;
    localparam logic [2:0] RED = 3'(bomb_pkg::WIRE_RED);
    localparam logic [2:0] BLU = 3'(bomb_pkg::WIRE_BLUE);
    localparam logic [2:0] WHT = 3'(bomb_pkg::WIRE_WHITE);
    localparam logic [2:0] YEL = 3'(bomb_pkg::WIRE_YELLOW);
    localparam logic [2:0] BLK = 3'(bomb_pkg::WIRE_BLACK);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table. Wire 5 is leftmost in each colour word.
    string names [NUM_TESTS] = '{"solve_no_red", "solve_one_red", "solve_many_red",
                                 "wrong_cuts", "timeout", "restart_quick"};
    logic [17:0] colors [NUM_TESTS] = '{
        {BLK, YEL, WHT, BLU, BLU, WHT},
        {BLU, WHT, BLK, RED, YEL, BLU},     // Red at 2.
        {RED, RED, BLK, WHT, RED, YEL},     // Reds at 1, 4 and 5.
        {BLU, YEL, RED, BLK, WHT, BLU},
        {WHT, RED, BLU, YEL, BLK, BLU},
        {BLK, YEL, WHT, BLU, BLU, WHT}
    };
    action_e actions [NUM_TESTS] = '{ACT_SOLVE, ACT_SOLVE, ACT_SOLVE,
                                     ACT_WRONG, ACT_TIMEOUT, ACT_SOLVE};
    bomb_pkg::game_state_e exp_states [NUM_TESTS] = '{
        bomb_pkg::GAME_DEFUSED, bomb_pkg::GAME_DEFUSED, bomb_pkg::GAME_DEFUSED,
        bomb_pkg::GAME_EXPLODED, bomb_pkg::GAME_EXPLODED, bomb_pkg::GAME_DEFUSED
    };
    logic [bomb_pkg::LIVES_W-1:0] exp_lives [NUM_TESTS] = '{2'd3, 2'd3, 2'd3, 2'd0, 2'd3, 2'd3};
    logic frame_en [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    logic [bomb_pkg::SSDEC_FRAME_W-1:0] exp_frames [NUM_TESTS] = '{
        12'h000, 12'h000, 12'h000, 12'h000, 12'h000, 12'h005
    };

    logic                                clk;
    logic                                rst_n;
    logic [5:0]                          button;
    logic [17:0]                         wire_colors;
    logic                                ssdec_ss;
    logic                                ssdec_sck;
    logic                                ssdec_sdi;
    bomb_pkg::game_state_e               game_state;
    logic [bomb_pkg::LIVES_W-1:0]        lives;
    logic [bomb_pkg::WIRE_POS_W-1:0]     wire_pos;
    logic [bomb_pkg::NUM_WIRES-1:0]      wire_status;
    logic [bomb_pkg::MIN_W-1:0]          cnt_min;
    logic [bomb_pkg::SEC_TEN_W-1:0]      cnt_sec_ten;
    logic [bomb_pkg::SEC_ONE_W-1:0]      cnt_sec_one;

    int pos;                // Cursor as the testbench expects it.
    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;
    int wrong_wires [$];

    bomb_game #(
        .CLKS_PER_SEC(20), .START_MIN(0), .START_SEC(5), .SCK_HALF(2)
    ) bomb_game_i (
        .clk(clk), .rst_n(rst_n), .button(button), .wire_colors(wire_colors),
        .ssdec_ss(ssdec_ss), .ssdec_sck(ssdec_sck), .ssdec_sdi(ssdec_sdi),
        .game_state(game_state), .lives(lives), .wire_pos(wire_pos),
        .wire_status(wire_status), .cnt_min(cnt_min), .cnt_sec_ten(cnt_sec_ten),
        .cnt_sec_one(cnt_sec_one)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    task automatic check_state(input string name, input bomb_pkg::game_state_e exp);
        if (game_state !== exp) begin
            $display("MISMATCH %s game_state expected %s actual %s",
                     name, exp.name(), game_state.name());
            test_errors++;
        end
    endtask

    task automatic check_lives(input string name, input logic [bomb_pkg::LIVES_W-1:0] exp);
        if (lives !== exp) begin
            $display("MISMATCH %s lives expected %0d actual %0d", name, exp, lives);
            test_errors++;
        end
    endtask

    task automatic check_status(input string name, input logic [5:0] exp);
        if (wire_status !== exp) begin
            $display("MISMATCH %s wire_status expected %b actual %b", name, exp, wire_status);
            test_errors++;
        end
    endtask

    task automatic check_pos(input string name,
                             input logic [bomb_pkg::WIRE_POS_W-1:0] exp);
        if (wire_pos !== exp) begin
            $display("MISMATCH %s wire_pos expected %0d actual %0d", name, exp, wire_pos);
            test_errors++;
        end
    endtask

    task automatic check_time(input string name,
                              input logic [bomb_pkg::MIN_W-1:0] exp_min,
                              input logic [bomb_pkg::SEC_TEN_W-1:0] exp_ten,
                              input logic [bomb_pkg::SEC_ONE_W-1:0] exp_one);
        if ({cnt_min, cnt_sec_ten, cnt_sec_one} !== {exp_min, exp_ten, exp_one}) begin
            $display("MISMATCH %s timer digits expected %0d:%0d%0d actual %0d:%0d%0d",
                     name, exp_min, exp_ten, exp_one, cnt_min, cnt_sec_ten, cnt_sec_one);
            test_errors++;
        end
    endtask

    task automatic check_frame(input string name,
                               input logic [bomb_pkg::SSDEC_FRAME_W-1:0] exp,
                               input logic [bomb_pkg::SSDEC_FRAME_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s ssdec frame expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and waits. All start and end on a falling clock edge.
    task automatic press(input int btn);
        button[btn] = 1'b1;
        repeat (4) @(negedge clk);
        button[btn] = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic move_to(input int target);
        while (pos != target) begin
            if ((target - pos + bomb_pkg::NUM_WIRES) % bomb_pkg::NUM_WIRES <= 3) begin
                press(bomb_pkg::BTN_RIGHT);
                pos = (pos + 1) % bomb_pkg::NUM_WIRES;
            end else begin
                press(bomb_pkg::BTN_LEFT);
                pos = (pos + bomb_pkg::NUM_WIRES - 1) % bomb_pkg::NUM_WIRES;
            end
        end
    endtask

    task automatic wait_state(input string name, input bomb_pkg::game_state_e exp,
                              input int limit);
        int n;
        n = 0;
        while (game_state != exp && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (game_state != exp) begin
            $display("%s: game state did not reach %s within %0d cycles",
                     name, exp.name(), limit);
            test_errors++;
        end
    endtask

    // Waits for ss to fall, then shifts in sdi on each rising sck.
    task automatic capture_frame(input string name,
                                 output logic [bomb_pkg::SSDEC_FRAME_W-1:0] frame);
        logic prev_ss;
        logic prev_sck;
        logic found;
        int   n;
        int   bits;
        frame = '0;
        found = 1'b0;
        bits = 0;
        for (n = 0; n < 200 && !found; n++) begin
            prev_ss = ssdec_ss;
            @(negedge clk);
            found = prev_ss && !ssdec_ss;
        end
        for (n = 0; n < 100 && found && bits < bomb_pkg::SSDEC_FRAME_W; n++) begin
            prev_sck = ssdec_sck;
            @(negedge clk);
            if (!prev_sck && ssdec_sck) begin
                frame = {frame[bomb_pkg::SSDEC_FRAME_W-2:0], ssdec_sdi};
                bits++;
            end
        end
        if (bits != bomb_pkg::SSDEC_FRAME_W) begin
            $display("%s: no complete seven-segment frame arrived in time", name);
            test_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model of the puzzle rule.
    function automatic int find_target(input logic [17:0] c);
        for (int w = bomb_pkg::NUM_WIRES - 1; w >= 0; w--) begin
            if (c[3*w +: 3] == RED) begin
                return w;
            end
        end
        return 0;
    endfunction

    // Three random wrong wires, cut left to right so the game ends before time-up.
    task automatic pick_wrong(input int target);
        int pool [$];
        int j;
        int tmp;
        pool = {};
        for (int w = 0; w < bomb_pkg::NUM_WIRES; w++) begin
            if (w != target) begin
                pool.push_back(w);
            end
        end
        for (int i = pool.size() - 1; i > 0; i--) begin
            j = $urandom_range(i, 0);
            tmp = pool[i];
            pool[i] = pool[j];
            pool[j] = tmp;
        end
        wrong_wires = {pool[0], pool[1], pool[2]};
        wrong_wires.sort();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence.
    initial begin
        logic [bomb_pkg::SSDEC_FRAME_W-1:0] frame;
        logic [5:0]                         exp_status;
        int                                 target;
        void'($urandom(83));
        button = '0;
        wire_colors = '0;
        rst_n = 1'b0;
        pos = 0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        check_state("reset", bomb_pkg::GAME_IDLE);
        check_lives("reset", bomb_pkg::START_LIVES);
        check_time("reset", 3'd0, 3'd0, 4'd5);
        capture_frame("reset", frame);
        check_frame("reset", 12'h005, frame);
        finish_test("reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            wire_colors = colors[t];
            target = find_target(colors[t]);
            exp_status = '0;
            pos = 0;
            press(bomb_pkg::BTN_SELECT);
            wait_state(names[t], bomb_pkg::GAME_PLAYING, 20);
            check_lives(names[t], bomb_pkg::START_LIVES);
            check_pos(names[t], 3'd0);
            check_time(names[t], 3'd0, 3'd0, 4'd5);     // Reloaded by start.
            if (actions[t] == ACT_SOLVE) begin
                move_to(target);
                check_pos(names[t], pos[bomb_pkg::WIRE_POS_W-1:0]);
                press(bomb_pkg::BTN_SELECT);
            end else if (actions[t] == ACT_WRONG) begin
                pick_wrong(target);
                for (int k = 0; k < 3; k++) begin
                    move_to(wrong_wires[k]);
                    check_pos(names[t], pos[bomb_pkg::WIRE_POS_W-1:0]);
                    press(bomb_pkg::BTN_SELECT);
                    exp_status[wrong_wires[k]] = 1'b1;
                    if (k == 0) begin
                        check_state(names[t], bomb_pkg::GAME_PLAYING);
                        check_lives(names[t], 2'd2);
                        check_status(names[t], exp_status);
                        press(bomb_pkg::BTN_SELECT);    // Same wire again.
                        check_state(names[t], bomb_pkg::GAME_PLAYING);
                        check_lives(names[t], 2'd2);
                        check_status(names[t], exp_status);
                    end
                end
            end
            wait_state(names[t], exp_states[t], 200);
            check_state(names[t], exp_states[t]);
            check_lives(names[t], exp_lives[t]);
            check_status(names[t], exp_status);
            if (frame_en[t]) begin
                check_time(names[t], exp_frames[t][10:8], exp_frames[t][6:4],
                           exp_frames[t][3:0]);
                capture_frame(names[t], frame);
                check_frame(names[t], exp_frames[t], frame);
            end
            press(bomb_pkg::BTN_BACK);
            wait_state(names[t], bomb_pkg::GAME_IDLE, 20);
            check_state(names[t], bomb_pkg::GAME_IDLE);
            finish_test(names[t]);
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/bomb_pkg.sv
hw/button_edge_detector.sv
hw/countdown_timer.sv
hw/wire_puzzle.sv
hw/game_control.sv
hw/ssdec_spi_master.sv
hw/bomb_game.sv
sim/bomb_game_properties.sv
sim/bomb_game_tb.sv

// File: Makefile
# Verilator build and run of bomb_game_tb. The log decides pass or fail.
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module bomb_game_tb \
		-Mdir obj_dir -o bomb_game_tb
	./obj_dir/bomb_game_tb > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "sim failed" $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
